/* bench/mem_stage_props.sv */
`timescale 1ns/100ps

module mem_stage_props (
    input logic                 clk,
    input logic                 reset,
    input logic                 ex_valid,
    input logic                 stall,
    input logic                 wb_valid,
    input memif_pkg::mem_cmd_e  req_cmd,
    input logic [1:0]           state
);

    // encodings of the stage's local state enum.
    localparam logic [1:0] idle_state      = 2'd0;
    localparam logic [1:0] wait_read_state = 2'd2;

    no_output_with_stall: assert property (
        @(posedge clk) disable iff (reset) !(wb_valid && stall)
    ) else $error("wb_out.valid and stall were high in the same cycle");

    no_cmd_in_wait_read: assert property (
        @(posedge clk) disable iff (reset)
        (state == wait_read_state) |-> (req_cmd == memif_pkg::CMD_NOP)
    ) else $error("a bus command was issued while a read was outstanding");

    // a stalled instruction keeps the stall up until its own output cycle.
    stall_ends_with_output: assert property (
        @(posedge clk) disable iff (reset) stall |=> (stall || wb_valid)
    ) else $error("stall fell without an output from the stalled instruction");

    idle_bubble_is_nop: assert property (
        @(posedge clk) disable iff (reset)
        (state == idle_state && !ex_valid) |-> (req_cmd == memif_pkg::CMD_NOP)
    ) else $error("a bus command was issued for a bubble in the idle state");

endmodule

bind memory_stage mem_stage_props u_props (
    .clk      (clk),
    .reset    (reset),
    .ex_valid (ex_in.valid),
    .stall    (stall),
    .wb_valid (wb_out.valid),
    .req_cmd  (mem_req.cmd),
    .state    (state)
);

/* bench/mem_stage_tb.sv */
`timescale 1ns/100ps

module mem_stage_tb;

    localparam int depth_words   = 256;
    localparam int accept_gap    = 2;
    localparam int read_latency  = 3;
    localparam int num_rows      = 24;
    localparam int timeout_limit = num_rows * (accept_gap + read_latency + 4) + 50;

    typedef struct packed {
        core_pkg::mem_op_e op;
        logic [31:0]       addr;
        logic [31:0]       wdata;
        logic              non_mem;
        logic [31:0]       exp_data;   // expected load result.
    } row_t;

    logic                    clk;
    logic                    reset;
    core_pkg::exmem_bundle_t ex_in;
    logic                    stall;
    core_pkg::memwb_bundle_t wb_out;

    row_t        rows [num_rows];
    logic [31:0] model_mem [depth_words];
    logic [31:0] lfsr_state;
    logic [31:0] gap_bits;
    int          mismatch_count;
    int          failure_count;
    int          rows_done;
    int          cycle_count;

    mem_subsystem_top #(
        .depth_words  (depth_words),
        .accept_gap   (accept_gap),
        .read_latency (read_latency)
    ) dut (
        .clk    (clk),
        .reset  (reset),
        .ex_in  (ex_in),
        .stall  (stall),
        .wb_out (wb_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic row_t make_row(core_pkg::mem_op_e op, logic [31:0] addr,
                                      logic [31:0] wdata, logic non_mem,
                                      logic [31:0] exp_data);
        row_t row;
        row.op       = op;
        row.addr     = addr;
        row.wdata    = wdata;
        row.non_mem  = non_mem;
        row.exp_data = exp_data;
        return row;
    endfunction

    function automatic logic is_load_op(core_pkg::mem_op_e op);
        case (op)
            core_pkg::MEM_LB, core_pkg::MEM_LBU, core_pkg::MEM_LH,
            core_pkg::MEM_LHU, core_pkg::MEM_LW: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic is_store_op(core_pkg::mem_op_e op);
        case (op)
            core_pkg::MEM_SB, core_pkg::MEM_SH, core_pkg::MEM_SW: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // subword loads take the low lanes of the word.
    function automatic logic [31:0] extend_load(core_pkg::mem_op_e op, logic [31:0] word);
        case (op)
            core_pkg::MEM_LB:  return {{24{word[7]}}, word[7:0]};
            core_pkg::MEM_LBU: return {24'h0, word[7:0]};
            core_pkg::MEM_LH:  return {{16{word[15]}}, word[15:0]};
            core_pkg::MEM_LHU: return {16'h0, word[15:0]};
            default:           return word;
        endcase
    endfunction

    task automatic apply_store(core_pkg::mem_op_e op, logic [31:0] addr, logic [31:0] data);
        logic [7:0] index;
        index = addr[9:2];
        case (op)
            core_pkg::MEM_SB: model_mem[index][7:0] = data[7:0];
            core_pkg::MEM_SH: model_mem[index][15:0] = data[15:0];
            default:          model_mem[index] = data;
        endcase
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h, got %h", name, exp, act);
            mismatch_count++;
        end
    endtask

    // expected load values follow from the stores earlier in the table.
    task automatic fill_rows();
        rows[0]  = make_row(core_pkg::MEM_NONE, 32'h1234_5678, 32'h0, 1'b1, 32'h0);
        rows[1]  = make_row(core_pkg::MEM_SW,  32'h40, 32'hdead_beef, 1'b0, 32'h0);
        rows[2]  = make_row(core_pkg::MEM_LW,  32'h40, 32'h0, 1'b0, 32'hdead_beef);
        rows[3]  = make_row(core_pkg::MEM_SW,  32'h44, 32'h1122_3344, 1'b0, 32'h0);
        rows[4]  = make_row(core_pkg::MEM_SB,  32'h44, 32'h0000_00a5, 1'b0, 32'h0);
        rows[5]  = make_row(core_pkg::MEM_LW,  32'h44, 32'h0, 1'b0, 32'h1122_33a5);
        rows[6]  = make_row(core_pkg::MEM_SH,  32'h44, 32'hffff_8001, 1'b0, 32'h0);
        rows[7]  = make_row(core_pkg::MEM_LW,  32'h44, 32'h0, 1'b0, 32'h1122_8001);
        rows[8]  = make_row(core_pkg::MEM_LB,  32'h44, 32'h0, 1'b0, 32'h0000_0001);
        rows[9]  = make_row(core_pkg::MEM_LBU, 32'h44, 32'h0, 1'b0, 32'h0000_0001);
        rows[10] = make_row(core_pkg::MEM_LH,  32'h44, 32'h0, 1'b0, 32'hffff_8001);
        rows[11] = make_row(core_pkg::MEM_LHU, 32'h44, 32'h0, 1'b0, 32'h0000_8001);
        rows[12] = make_row(core_pkg::MEM_LBU, 32'h40, 32'h0, 1'b0, 32'h0000_00ef);
        rows[13] = make_row(core_pkg::MEM_LB,  32'h40, 32'h0, 1'b0, 32'hffff_ffef);
        rows[14] = make_row(core_pkg::MEM_LH,  32'h40, 32'h0, 1'b0, 32'hffff_beef);
        rows[15] = make_row(core_pkg::MEM_NONE, 32'hcafe_0001, 32'h0, 1'b1, 32'h0);
        rows[16] = make_row(core_pkg::MEM_SW,  32'h48, 32'h7f7f_7f7f, 1'b0, 32'h0);
        rows[17] = make_row(core_pkg::MEM_LB,  32'h48, 32'h0, 1'b0, 32'h0000_007f);
        rows[18] = make_row(core_pkg::MEM_LH,  32'h48, 32'h0, 1'b0, 32'h0000_7f7f);
        rows[19] = make_row(core_pkg::MEM_SB,  32'h48, 32'habcd_ef80, 1'b0, 32'h0);
        rows[20] = make_row(core_pkg::MEM_LBU, 32'h48, 32'h0, 1'b0, 32'h0000_0080);
        rows[21] = make_row(core_pkg::MEM_LHU, 32'h48, 32'h0, 1'b0, 32'h0000_7f80);
        rows[22] = make_row(core_pkg::MEM_LW,  32'h48, 32'h0, 1'b0, 32'h7f7f_7f80);
        rows[23] = make_row(core_pkg::MEM_NONE, 32'h0000_0100, 32'h0, 1'b1, 32'h0);
    endtask

    // called on a falling edge; returns on the falling edge after the output cycle.
    task automatic run_row(input int idx);
        core_pkg::exmem_bundle_t bundle;
        core_pkg::memwb_bundle_t seen;
        row_t                    row;
        logic [31:0]             bits;
        logic [31:0]             predicted;
        int                      waited;
        logic                    done;
        row = rows[idx];
        bundle = '0;
        bundle.valid = 1'b1;
        take_bits(32, bits);
        bundle.pc = {bits[31:2], 2'b00};
        take_bits(32, bits);
        bundle.br_target = bits;
        take_bits(5, bits);
        bundle.wb_addr = bits[4:0];
        take_bits(4, bits);
        bundle.br_flg   = bits[0];
        bundle.rf_wen   = bits[1];
        bundle.jmp_flg  = bits[2];
        bundle.is_ecall = bits[3];
        bundle.alu_out  = row.addr;
        bundle.rs2_data = row.wdata;
        bundle.mem_op   = row.non_mem ? core_pkg::MEM_NONE : row.op;
        if (is_load_op(bundle.mem_op)) begin
            bundle.wb_sel = core_pkg::WB_MEM;
        end else if (is_store_op(bundle.mem_op)) begin
            bundle.wb_sel = core_pkg::WB_NONE;
        end else begin
            bundle.wb_sel = core_pkg::WB_ALU;
        end
        ex_in = bundle;

        waited = 0;
        done = 1'b0;
        while (!done) begin
            #1;
            if (wb_out.valid === 1'b1) begin
                seen = wb_out;
                if (stall !== 1'b0) begin
                    $display("row %0d: stall was high in the output cycle", idx);
                    failure_count++;
                end
                done = 1'b1;
            end else if (stall !== 1'b1) begin
                $display("row %0d: neither an output nor a stall for a presented instruction",
                         idx);
                failure_count++;
                @(negedge clk);
                return;
            end else begin
                waited++;
            end
            @(negedge clk);
        end

        if (row.non_mem && waited != 0) begin
            $display("row %0d: non-memory instruction took %0d extra cycles", idx, waited);
            failure_count++;
        end
        check_value("wb_out.pc", bundle.pc, seen.pc);
        check_value("wb_out.alu_out", bundle.alu_out, seen.alu_out);
        check_value("wb_out.br_flg", 32'(bundle.br_flg), 32'(seen.br_flg));
        check_value("wb_out.br_target", bundle.br_target, seen.br_target);
        check_value("wb_out.rf_wen", 32'(bundle.rf_wen), 32'(seen.rf_wen));
        check_value("wb_out.wb_sel", 32'(bundle.wb_sel), 32'(seen.wb_sel));
        check_value("wb_out.wb_addr", 32'(bundle.wb_addr), 32'(seen.wb_addr));
        check_value("wb_out.jmp_flg", 32'(bundle.jmp_flg), 32'(seen.jmp_flg));
        check_value("wb_out.is_ecall", 32'(bundle.is_ecall), 32'(seen.is_ecall));

        if (is_load_op(bundle.mem_op)) begin
            predicted = extend_load(row.op, model_mem[row.addr[9:2]]);
            if (predicted !== row.exp_data) begin
                $display("row %0d: table value %h disagrees with the memory model value %h",
                         idx, row.exp_data, predicted);
                failure_count++;
            end
            check_value("wb_out.read_data", row.exp_data, seen.read_data);
        end else if (is_store_op(bundle.mem_op)) begin
            apply_store(row.op, row.addr, row.wdata);
        end
        rows_done++;
    endtask

    task automatic finish_run();
        $display("summary: %0d of %0d rows done, %0d mismatches, %0d other errors",
                 rows_done, num_rows, mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", timeout_limit);
        failure_count++;
        finish_run();
    end

    initial begin
        lfsr_state     = 32'd44;
        mismatch_count = 0;
        failure_count  = 0;
        rows_done      = 0;
        reset          = 1'b1;
        ex_in          = '0;
        fill_rows();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        check_value("stall", 32'h0, 32'(stall));
        check_value("wb_out.valid", 32'h0, 32'(wb_out.valid));
        @(negedge clk);

        for (int i = 0; i < num_rows; i++) begin
            run_row(i);
            take_bits(1, gap_bits);
            if (gap_bits[0]) begin
                ex_in.valid = 1'b0;   // one bubble between rows.
                #1;
                check_value("stall", 32'h0, 32'(stall));
                check_value("wb_out.valid", 32'h0, 32'(wb_out.valid));
                @(negedge clk);
            end
        end
        ex_in = '0;
        @(negedge clk);
        finish_run();
    end

endmodule

/* filelist.f */
verilog/core_pkg.sv
verilog/memif_pkg.sv
verilog/memory_stage.sv
verilog/data_memory.sv
verilog/mem_subsystem_top.sv
bench/mem_stage_props.sv
bench/mem_stage_tb.sv

/* verilog/core_pkg.sv */
package core_pkg;

    // memory operation carried by an instruction into the memory stage.
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LBU  = 4'd2,
        MEM_LH   = 4'd3,
        MEM_LHU  = 4'd4,
        MEM_LW   = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_e;

    typedef enum logic [2:0] {
        WB_NONE = 3'd0,
        WB_ALU  = 3'd1,
        WB_MEM  = 3'd2,
        WB_PC4  = 3'd3,
        WB_CSR  = 3'd4
    } wb_sel_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] alu_out;    // doubles as the memory address.
        logic [31:0] rs2_data;   // store data.
        logic        br_flg;
        logic [31:0] br_target;
        mem_op_e     mem_op;
        logic        rf_wen;
        wb_sel_e     wb_sel;
        logic [4:0]  wb_addr;
        logic        jmp_flg;
        logic        is_ecall;
    } exmem_bundle_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] alu_out;
        logic [31:0] read_data;  // extended load result, zero for other instructions.
        logic        br_flg;
        logic [31:0] br_target;
        logic        rf_wen;
        wb_sel_e     wb_sel;
        logic [4:0]  wb_addr;
        logic        jmp_flg;
        logic        is_ecall;
    } memwb_bundle_t;

endpackage

/* verilog/data_memory.sv */
`timescale 1ns/100ps

module data_memory #(
    parameter int depth_words  = 256,
    parameter int accept_gap   = 2,
    parameter int read_latency = 3
) (
    input  logic                clk,
    input  logic                reset,
    input  memif_pkg::mem_req_t mem_req,
    output memif_pkg::mem_rsp_t mem_rsp
);

    localparam int addr_bits = (depth_words > 1) ? $clog2(depth_words) : 1;
    localparam int gap_bits  = (accept_gap > 0) ? $clog2(accept_gap + 1) : 1;

    logic [31:0] ram [depth_words];

    logic [gap_bits-1:0]     gap_count;
    logic                    cmd_ready;
    logic                    accepted;
    logic                    accepted_read;
    logic                    accepted_write;
    logic [addr_bits-1:0]    word_index;

    logic [read_latency-1:0] valid_pipe;
    logic [31:0]             data_pipe [read_latency];

    assign cmd_ready      = (gap_count == '0);
    assign accepted       = (mem_req.cmd != memif_pkg::CMD_NOP) && cmd_ready;
    assign accepted_read  = accepted && (mem_req.cmd == memif_pkg::CMD_READ);
    assign accepted_write = accepted && (mem_req.cmd == memif_pkg::CMD_WRITE);

    assign word_index = mem_req.addr[addr_bits+1:2]; // byte offset bits are dropped.

    // after each accepted command the memory refuses new ones for accept_gap cycles.
    always_ff @(posedge clk) begin
        if (reset) begin
            gap_count <= '0;
        end else if (accepted) begin
            gap_count <= gap_bits'(accept_gap);
        end else if (gap_count != '0) begin
            gap_count <= gap_count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accepted_write) begin
            ram[word_index] <= (ram[word_index] & ~mem_req.wmask) |
                               (mem_req.wdata & mem_req.wmask);
        end
    end

    // read word and its valid bit ride the same shift register.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= accepted_read;
            for (int i = read_latency - 1; i > 0; i--) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        data_pipe[0] <= ram[word_index];
        for (int i = read_latency - 1; i > 0; i--) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    always_comb begin
        mem_rsp.cmd_ready   = cmd_ready;
        mem_rsp.rdata       = data_pipe[read_latency-1];
        mem_rsp.rdata_valid = valid_pipe[read_latency-1];
    end

endmodule

/* verilog/mem_subsystem_top.sv */
`timescale 1ns/100ps

module mem_subsystem_top #(
    parameter int depth_words  = 256,
    parameter int accept_gap   = 2,
    parameter int read_latency = 3
) (
    input  logic                    clk,
    input  logic                    reset,
    input  core_pkg::exmem_bundle_t ex_in,
    output logic                    stall,
    output core_pkg::memwb_bundle_t wb_out
);

    memif_pkg::mem_req_t mem_req;
    memif_pkg::mem_rsp_t mem_rsp;

    // the pipeline stage that turns loads and stores into bus commands.
    memory_stage u_memory_stage (
        .clk     (clk),
        .reset   (reset),
        .ex_in   (ex_in),
        .stall   (stall),
        .wb_out  (wb_out),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    data_memory #(
        .depth_words  (depth_words),
        .accept_gap   (accept_gap),
        .read_latency (read_latency)
    ) u_data_memory (
        .clk     (clk),
        .reset   (reset),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

/* verilog/memif_pkg.sv */
package memif_pkg;

    typedef enum logic [1:0] {
        CMD_NOP   = 2'd0,
        CMD_READ  = 2'd1,
        CMD_WRITE = 2'd2
    } mem_cmd_e;

    // a command counts as accepted when cmd is not CMD_NOP and cmd_ready is high.
    typedef struct packed {
        mem_cmd_e    cmd;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] wmask;  // one bit per data bit.
    } mem_req_t;

    typedef struct packed {
        logic        cmd_ready;
        logic [31:0] rdata;
        logic        rdata_valid;
    } mem_rsp_t;

endpackage

/* verilog/memory_stage.sv */
`timescale 1ns/100ps

module memory_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  core_pkg::exmem_bundle_t ex_in,
    output logic                    stall,
    output core_pkg::memwb_bundle_t wb_out,
    output memif_pkg::mem_req_t     mem_req,
    input  memif_pkg::mem_rsp_t     mem_rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_READY,
        ST_WAIT_READ
    } state_e;

    state_e state;
    state_e state_next;

    core_pkg::exmem_bundle_t saved;
    core_pkg::exmem_bundle_t cur;

    logic        cur_store;
    logic        cur_load;
    logic        cur_mem;
    logic        cmd_taken;
    logic        out_fire;
    logic [31:0] load_data;

    function automatic logic op_is_store(core_pkg::mem_op_e op);
        return op == core_pkg::MEM_SB || op == core_pkg::MEM_SH || op == core_pkg::MEM_SW;
    endfunction

    function automatic logic op_is_load(core_pkg::mem_op_e op);
        return op == core_pkg::MEM_LB || op == core_pkg::MEM_LBU ||
               op == core_pkg::MEM_LH || op == core_pkg::MEM_LHU ||
               op == core_pkg::MEM_LW;
    endfunction

    // in idle the live bundle drives everything, otherwise the held copy does.
    assign cur = (state == ST_IDLE) ? ex_in : saved;

    assign cur_store = cur.valid && op_is_store(cur.mem_op);
    assign cur_load  = cur.valid && op_is_load(cur.mem_op);
    assign cur_mem   = cur_store || cur_load;

    always_comb begin
        mem_req.addr  = cur.alu_out;
        mem_req.wdata = cur.rs2_data;
        case (cur.mem_op)
            core_pkg::MEM_SB: mem_req.wmask = 32'h0000_00ff;
            core_pkg::MEM_SH: mem_req.wmask = 32'h0000_ffff;
            default:          mem_req.wmask = 32'hffff_ffff;
        endcase

        if (state == ST_WAIT_READ) begin
            mem_req.cmd = memif_pkg::CMD_NOP; // only one read may be in flight.
        end else if (cur_store) begin
            mem_req.cmd = memif_pkg::CMD_WRITE;
        end else if (cur_load) begin
            mem_req.cmd = memif_pkg::CMD_READ;
        end else begin
            mem_req.cmd = memif_pkg::CMD_NOP;
        end
    end

    assign cmd_taken = (mem_req.cmd != memif_pkg::CMD_NOP) && mem_rsp.cmd_ready;

    // out_fire marks the single cycle in which an instruction leaves the stage.
    always_comb begin
        case (state)
            ST_IDLE:       out_fire = ex_in.valid && (!cur_mem || (cur_store && cmd_taken));
            ST_WAIT_READY: out_fire = cur_store && cmd_taken;
            ST_WAIT_READ:  out_fire = mem_rsp.rdata_valid;
            default:       out_fire = 1'b0;
        endcase
    end

    assign stall = cur_mem && !out_fire; // pending memory work holds the upstream stages.

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (cur_mem) begin
                    if (!cmd_taken) begin
                        state_next = ST_WAIT_READY;
                    end else if (cur_load) begin
                        state_next = ST_WAIT_READ;
                    end
                end
            end
            ST_WAIT_READY: begin
                if (cmd_taken) begin
                    state_next = cur_load ? ST_WAIT_READ : ST_IDLE;
                end
            end
            ST_WAIT_READ: begin
                if (mem_rsp.rdata_valid) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // the whole bundle is captured on the way out of idle.
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && state_next != ST_IDLE) begin
            saved <= ex_in;
        end
    end

    always_comb begin
        case (saved.mem_op)
            core_pkg::MEM_LB:  load_data = {{24{mem_rsp.rdata[7]}}, mem_rsp.rdata[7:0]};
            core_pkg::MEM_LBU: load_data = {24'b0, mem_rsp.rdata[7:0]};
            core_pkg::MEM_LH:  load_data = {{16{mem_rsp.rdata[15]}}, mem_rsp.rdata[15:0]};
            core_pkg::MEM_LHU: load_data = {16'b0, mem_rsp.rdata[15:0]};
            default:           load_data = mem_rsp.rdata;
        endcase
    end

    always_comb begin
        wb_out.valid     = out_fire;
        wb_out.pc        = cur.pc;
        wb_out.alu_out   = cur.alu_out;
        wb_out.read_data = (state == ST_WAIT_READ) ? load_data : 32'b0;
        wb_out.br_flg    = cur.br_flg;
        wb_out.br_target = cur.br_target;
        wb_out.rf_wen    = cur.rf_wen;
        wb_out.wb_sel    = cur.wb_sel;
        wb_out.wb_addr   = cur.wb_addr;
        wb_out.jmp_flg   = cur.jmp_flg;
        wb_out.is_ecall  = cur.is_ecall;
    end

endmodule
